// ==== source/cdi_glue_pkg.sv ====
package cdi_glue_pkg;

    // ============================================================
    // Widths and constants
    // ============================================================

    localparam int SDRAM_ADDR_W = 25;
    localparam int DATA_W = 16;
    localparam int WORM_ADDR_W = 13;

    // Upper SDRAM address bits of the boot ROM region
    localparam logic [2:0] ROM_REGION_PREFIX = 3'b001;

    // Position of the select bit in the host download index
    localparam int ROM_INDEX_BIT = 6;

    // Four seconds at 30 MHz
    localparam int unsigned NVRAM_BOOT_IGNORE_CYCLES = 120_000_000;

    // ============================================================
    // Bundles
    // ============================================================

    typedef struct packed {
        logic [SDRAM_ADDR_W-1:0] addr;
        logic [DATA_W-1:0]       data;
        logic                    rd;
        logic                    wr;
        logic                    word;
        logic                    refresh;
        logic                    burst;
    } sdram_req_t;

    typedef struct packed {
        logic                    pending;
        logic [SDRAM_ADDR_W-1:0] addr;
        logic [DATA_W-1:0]       data;
    } rom_write_t;

    // One host download beat, index6 set means slave WORM
    typedef struct packed {
        logic                    wr;
        logic [SDRAM_ADDR_W-1:0] addr;
        logic [DATA_W-1:0]       data;
        logic                    index6;
    } host_dl_t;

    typedef struct packed {
        logic [WORM_ADDR_W-1:0] addr;
        logic [7:0]             restore_data;
        logic                   restore_write;
        logic                   allow_cpu_access;
    } nvram_core_t;

    typedef enum logic [1:0] {
        OWNER_ROM,
        OWNER_REFRESH,
        OWNER_IDLE
    } sdram_owner_e;

    typedef enum logic [3:0] {
        IDLE,
        WAIT_ACK,
        BACKUP0,
        BACKUP1,
        BACKUP2,
        BACKUP3,
        RESTORE0,
        RESTORE1,
        RESTORE2
    } nvram_state_e;

endpackage

// ==== source/rom_loader.sv ====
`timescale 1ns/1ns

module rom_loader (
    input  logic                     clk_sys,
    input  logic                     cditop_reset,
    input  cdi_glue_pkg::host_dl_t   dl,
    input  logic                     rom_done,
    output cdi_glue_pkg::rom_write_t rom_wr,
    output logic                     download_overflow
);
    import cdi_glue_pkg::*;

    logic                    rom_beat;
    logic                    pending;
    logic [SDRAM_ADDR_W-1:0] wr_addr;
    logic [DATA_W-1:0]       wr_data;

    // Main CPU ROM has the index select bit clear
    assign rom_beat = dl.wr && !dl.index6;

    // ============================================================
    // Pending flag and overflow detection
    // ============================================================

    always_ff @(posedge clk_sys) begin
        if (cditop_reset) begin
            pending <= 1'b0;
            download_overflow <= 1'b0;
        end else begin
            // Host sent the next word before the last one reached SDRAM
            if (rom_beat && pending) begin
                download_overflow <= 1'b1;
            end

            if (rom_beat) begin
                pending <= 1'b1;
            end else if (rom_done) begin
                pending <= 1'b0;
            end
        end
    end

    // Word address inside the ROM region, bytes swapped for the 68k
    always_ff @(posedge clk_sys) begin
        if (rom_beat) begin
            wr_addr <= {ROM_REGION_PREFIX, dl.addr[21:1], 1'b0};
            wr_data <= {dl.data[7:0], dl.data[15:8]};
        end
    end

    assign rom_wr = '{pending: pending, addr: wr_addr, data: wr_data};

endmodule

// ==== source/worm_loader.sv ====
`timescale 1ns/1ns

module worm_loader (
    input  logic                                 clk_sys,
    input  cdi_glue_pkg::host_dl_t               dl,
    output logic [cdi_glue_pkg::WORM_ADDR_W-1:0] worm_adr,
    output logic [7:0]                           worm_data,
    output logic                                 worm_wr
);

    logic       worm_beat;
    logic       worm_beat_q;
    logic [7:0] high_byte;

    assign worm_beat = dl.wr && dl.index6;

    // Two write cycles per host word
    always_ff @(posedge clk_sys) begin
        worm_beat_q <= worm_beat;
        worm_wr <= worm_beat || worm_beat_q;
    end

    always_ff @(posedge clk_sys) begin
        if (worm_beat) begin
            // Low byte goes out first
            worm_adr <= dl.addr[12:0];
            worm_data <= dl.data[7:0];
            high_byte <= dl.data[15:8];
        end else begin
            worm_data <= high_byte;
            worm_adr[0] <= 1'b1;
        end
    end

endmodule

// ==== source/sdram_arbiter.sv ====
`timescale 1ns/1ns

module sdram_arbiter (
    input  logic                     clk_sys,
    input  logic                     cditop_reset,
    input  logic                     menu_reset,
    input  logic                     download,
    input  logic                     mount_reset,
    input  cdi_glue_pkg::rom_write_t rom_wr,
    output logic                     rom_done,
    input  cdi_glue_pkg::sdram_req_t core_req,
    input  logic                     sdram_busy,
    output cdi_glue_pkg::sdram_req_t sdram_req,
    output logic                     core_hold
);
    import cdi_glue_pkg::*;

    sdram_owner_e owner_q;
    sdram_owner_e owner_next;
    sdram_owner_e owner;
    logic         busy_q;
    sdram_req_t   boot_req;

    // Core stays stopped while SDRAM is prepared
    always_ff @(posedge clk_sys) begin
        core_hold <= cditop_reset || menu_reset || download || mount_reset;
    end

    always_ff @(posedge clk_sys) begin
        if (cditop_reset) begin
            owner_q <= OWNER_IDLE;
            busy_q <= 1'b0;
        end else begin
            owner_q <= owner;
            busy_q <= sdram_busy;
        end
    end

    // ROM write finished when busy drops
    assign rom_done = (owner_q == OWNER_ROM) && busy_q && !sdram_busy;

    // ============================================================
    // Owner selection
    // ============================================================

    always_comb begin
        owner_next = OWNER_IDLE;

        if (core_hold) begin
            // Pending flag is still set in the cycle of rom_done, skip it
            if (rom_wr.pending && !rom_done) begin
                owner_next = OWNER_ROM;
            end else begin
                owner_next = OWNER_REFRESH;
            end
        end

        // No change of owner during an access
        owner = sdram_busy ? owner_q : owner_next;
    end

    // ============================================================
    // Boot request and mux
    // ============================================================

    always_comb begin
        boot_req = '0;
        boot_req.word = 1'b1;

        case (owner)
            OWNER_ROM: begin
                boot_req.addr = rom_wr.addr;
                boot_req.data = rom_wr.data;
                boot_req.wr = 1'b1;
            end
            OWNER_REFRESH: begin
                boot_req.rd = 1'b1;
                boot_req.refresh = 1'b1;
            end
            default: begin
            end
        endcase

        if (sdram_busy) begin
            boot_req.rd = 1'b0;
            boot_req.wr = 1'b0;
        end
    end

    assign sdram_req = core_hold ? boot_req : core_req;

endmodule

// ==== source/nvram_sync.sv ====
`timescale 1ns/1ns

module nvram_sync #(
    parameter int unsigned IGNORE_CYCLES = cdi_glue_pkg::NVRAM_BOOT_IGNORE_CYCLES
) (
    input  logic                            clk_sys,
    input  logic                            cditop_reset,
    input  logic                            nvram_mount,
    input  logic                            img_size_nonzero,
    input  logic                            reset_on_mount,
    output logic                            mount_reset,
    input  logic                            osd_status,
    input  logic                            nvram_hps_ack,
    input  logic                            sd_buff_addr_lsb,
    input  logic [cdi_glue_pkg::DATA_W-1:0] sd_buff_dout,
    input  logic                            sd_buff_wr,
    output logic                            nvram_hps_rd,
    output logic                            nvram_hps_wr,
    output logic [cdi_glue_pkg::DATA_W-1:0] nvram_hps_din,
    input  logic [7:0]                      nvram_backup_data,
    input  logic                            nvram_cpu_changed,
    output cdi_glue_pkg::nvram_core_t       nvram_core,
    output logic                            backup_led
);
    import cdi_glue_pkg::*;

    localparam int CNT_W = $clog2(IGNORE_CYCLES + 1);

    nvram_state_e           state;
    logic                   img_mount;
    logic                   image_mounted;
    logic [CNT_W-1:0]       ignore_cnt;
    logic                   change_seen;
    logic                   backup_pending;
    logic                   osd_status_q;
    logic                   osd_rise;
    logic                   addr_lsb_q;
    logic                   addr_toggle;
    logic [WORM_ADDR_W-1:0] byte_adr;
    logic [DATA_W-1:0]      restore_word;
    logic [DATA_W-1:0]      backup_word;
    logic                   restore_write;
    logic                   allow_cpu_access;

    assign img_mount = nvram_mount && img_size_nonzero;
    assign mount_reset = img_mount && reset_on_mount;
    assign backup_led = backup_pending;

    always_ff @(posedge clk_sys) begin
        osd_status_q <= osd_status;
        addr_lsb_q <= sd_buff_addr_lsb;
    end

    assign osd_rise = osd_status && !osd_status_q;
    assign addr_toggle = sd_buff_addr_lsb != addr_lsb_q;

    // The OS writes NvRAM while booting, those changes are not worth a backup
    always_ff @(posedge clk_sys) begin
        if (cditop_reset) begin
            image_mounted <= 1'b0;
            ignore_cnt <= CNT_W'(IGNORE_CYCLES);
        end else begin
            if (nvram_mount) begin
                image_mounted <= img_size_nonzero;
            end
            if (ignore_cnt != '0) begin
                ignore_cnt <= ignore_cnt - 1'b1;
            end
        end
    end

    assign change_seen = (ignore_cnt == '0) && nvram_cpu_changed && image_mounted;

    // ============================================================
    // Restore and backup FSM
    // ============================================================

    always_ff @(posedge clk_sys) begin
        if (cditop_reset) begin
            state <= IDLE;
            nvram_hps_rd <= 1'b0;
            nvram_hps_wr <= 1'b0;
            restore_write <= 1'b0;
            allow_cpu_access <= 1'b1;
            byte_adr <= '0;
            backup_pending <= 1'b0;
        end else begin
            restore_write <= 1'b0;

            if (change_seen) begin
                backup_pending <= 1'b1;
            end

            // Host request is a level, acknowledge clears it
            if (nvram_hps_ack) begin
                nvram_hps_rd <= 1'b0;
                nvram_hps_wr <= 1'b0;
            end

            case (state)
                IDLE: begin
                    allow_cpu_access <= 1'b1;
                    byte_adr <= '0;

                    if (img_mount) begin
                        // Fresh image replaces the NvRAM content
                        nvram_hps_rd <= 1'b1;
                        allow_cpu_access <= 1'b0;
                        state <= WAIT_ACK;
                    end else if (backup_pending && osd_rise) begin
                        // Opening the OSD saves a changed NvRAM
                        backup_pending <= 1'b0;
                        nvram_hps_wr <= 1'b1;
                        allow_cpu_access <= 1'b0;
                        state <= WAIT_ACK;
                    end
                end
                WAIT_ACK: begin
                    if (nvram_hps_ack) begin
                        state <= nvram_hps_rd ? RESTORE0 : BACKUP0;
                    end
                end
                // Collect both bytes, then publish the whole word
                BACKUP0: begin
                    byte_adr <= byte_adr + 1'b1;
                    state <= BACKUP1;
                end
                BACKUP1: begin
                    byte_adr <= byte_adr + 1'b1;
                    state <= BACKUP2;
                end
                BACKUP2: begin
                    state <= BACKUP3;
                end
                BACKUP3: begin
                    if (addr_toggle) begin
                        state <= BACKUP0;
                    end
                    if (!nvram_hps_ack) begin
                        state <= IDLE;
                    end
                end
                RESTORE0: begin
                    if (sd_buff_wr) begin
                        restore_write <= 1'b1;
                        state <= RESTORE1;
                    end
                    if (!nvram_hps_ack) begin
                        allow_cpu_access <= 1'b1;
                        state <= IDLE;
                    end
                end
                RESTORE1: begin
                    // High byte at the odd address
                    restore_write <= 1'b1;
                    byte_adr <= byte_adr + 1'b1;
                    state <= RESTORE2;
                end
                RESTORE2: begin
                    byte_adr <= byte_adr + 1'b1;
                    state <= RESTORE0;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Data words
    always_ff @(posedge clk_sys) begin
        if (state == RESTORE0 && sd_buff_wr) begin
            restore_word <= sd_buff_dout;
        end
        if (state == BACKUP0) begin
            backup_word[7:0] <= nvram_backup_data;
        end
        if (state == BACKUP1) begin
            backup_word[15:8] <= nvram_backup_data;
        end
        if (state == BACKUP2) begin
            nvram_hps_din <= backup_word;
        end
    end

    assign nvram_core = '{
        addr: byte_adr,
        restore_data: byte_adr[0] ? restore_word[15:8] : restore_word[7:0],
        restore_write: restore_write,
        allow_cpu_access: allow_cpu_access
    };

endmodule

// ==== source/cdi_host_glue.sv ====
`timescale 1ns/1ns

module cdi_host_glue #(
    parameter int unsigned IGNORE_CYCLES = cdi_glue_pkg::NVRAM_BOOT_IGNORE_CYCLES
) (
    input  logic                                 clk_sys,
    input  logic                                 cditop_reset,
    input  logic                                 menu_reset,
    input  logic                                 download,
    input  cdi_glue_pkg::host_dl_t               dl,
    input  cdi_glue_pkg::sdram_req_t             core_req,
    input  logic                                 sdram_busy,
    input  logic [cdi_glue_pkg::DATA_W-1:0]      sdram_dout,
    input  logic                                 sdram_burstdata_valid,
    input  logic                                 nvram_hps_ack,
    input  logic                                 sd_buff_addr_lsb,
    input  logic [cdi_glue_pkg::DATA_W-1:0]      sd_buff_dout,
    input  logic                                 sd_buff_wr,
    input  logic                                 nvram_mount,
    input  logic                                 img_size_nonzero,
    input  logic                                 osd_status,
    input  logic [7:0]                           nvram_backup_data,
    input  logic                                 nvram_cpu_changed,
    input  logic                                 reset_on_mount,
    output cdi_glue_pkg::sdram_req_t             sdram_req,
    output logic                                 core_hold,
    output logic                                 download_overflow,
    output logic [cdi_glue_pkg::WORM_ADDR_W-1:0] worm_adr,
    output logic [7:0]                           worm_data,
    output logic                                 worm_wr,
    output logic                                 nvram_hps_rd,
    output logic                                 nvram_hps_wr,
    output logic [cdi_glue_pkg::DATA_W-1:0]      nvram_hps_din,
    output cdi_glue_pkg::nvram_core_t            nvram_core,
    output logic                                 backup_led
);
    import cdi_glue_pkg::*;

    rom_write_t rom_wr;
    logic       rom_done;
    logic       mount_reset;

    rom_loader u_rom_loader (
        .clk_sys          (clk_sys),
        .cditop_reset     (cditop_reset),
        .dl               (dl),
        .rom_done         (rom_done),
        .rom_wr           (rom_wr),
        .download_overflow(download_overflow)
    );

    worm_loader u_worm_loader (
        .clk_sys  (clk_sys),
        .dl       (dl),
        .worm_adr (worm_adr),
        .worm_data(worm_data),
        .worm_wr  (worm_wr)
    );

    sdram_arbiter u_sdram_arbiter (
        .clk_sys     (clk_sys),
        .cditop_reset(cditop_reset),
        .menu_reset  (menu_reset),
        .download    (download),
        .mount_reset (mount_reset),
        .rom_wr      (rom_wr),
        .rom_done    (rom_done),
        .core_req    (core_req),
        .sdram_busy  (sdram_busy),
        .sdram_req   (sdram_req),
        .core_hold   (core_hold)
    );

    nvram_sync #(
        .IGNORE_CYCLES(IGNORE_CYCLES)
    ) u_nvram_sync (
        .clk_sys          (clk_sys),
        .cditop_reset     (cditop_reset),
        .nvram_mount      (nvram_mount),
        .img_size_nonzero (img_size_nonzero),
        .reset_on_mount   (reset_on_mount),
        .mount_reset      (mount_reset),
        .osd_status       (osd_status),
        .nvram_hps_ack    (nvram_hps_ack),
        .sd_buff_addr_lsb (sd_buff_addr_lsb),
        .sd_buff_dout     (sd_buff_dout),
        .sd_buff_wr       (sd_buff_wr),
        .nvram_hps_rd     (nvram_hps_rd),
        .nvram_hps_wr     (nvram_hps_wr),
        .nvram_hps_din    (nvram_hps_din),
        .nvram_backup_data(nvram_backup_data),
        .nvram_cpu_changed(nvram_cpu_changed),
        .nvram_core       (nvram_core),
        .backup_led       (backup_led)
    );

endmodule

// ==== tests/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD = 4,
    parameter int RESET_CYCLES = 2
) (
    output logic clk_sys,
    output logic cditop_reset
);

    initial begin
        clk_sys = 1'b0;
        forever #(PERIOD / 2) clk_sys = ~clk_sys;
    end

    // Reset is seen by the first RESET_CYCLES rising edges
    initial begin
        cditop_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_sys);
        #1 cditop_reset = 1'b0;
    end

endmodule

// ==== tests/tb_cdi_host_glue.sv ====
`timescale 1ns/1ns

module tb_cdi_host_glue;
    import cdi_glue_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 2;
    localparam int BUSY_CYCLES = 3;
    localparam int ROM_BEATS = 10;
    localparam int ROM_GAP = 12;
    localparam int WORM_BEATS = 8;
    localparam int WORM_GAP = 3;
    localparam int PASS_CYCLES = 24;
    localparam int NV_WORDS = 6;
    localparam int RESTORE_GAP = 4;
    localparam int BACKUP_GAP = 8;
    localparam int WAIT_LIMIT = 40;
    localparam int REQ_W = $bits(sdram_req_t);
    localparam int RUN_CYCLES = 40 + ROM_BEATS * ROM_GAP + WORM_BEATS * WORM_GAP
        + PASS_CYCLES + NV_WORDS * (RESTORE_GAP + BACKUP_GAP) + 12 * WAIT_LIMIT;

    logic                   clk_sys;
    logic                   cditop_reset;
    logic                   menu_reset;
    logic                   download;
    host_dl_t               dl;
    sdram_req_t             core_req;
    logic                   sdram_busy;
    logic [DATA_W-1:0]      sdram_dout;
    logic                   sdram_burstdata_valid;
    logic                   nvram_hps_ack;
    logic                   sd_buff_addr_lsb;
    logic [DATA_W-1:0]      sd_buff_dout;
    logic                   sd_buff_wr;
    logic                   nvram_mount;
    logic                   img_size_nonzero;
    logic                   osd_status;
    logic [7:0]             nvram_backup_data;
    logic                   nvram_cpu_changed;
    logic                   reset_on_mount;
    sdram_req_t             sdram_req;
    logic                   core_hold;
    logic                   download_overflow;
    logic [WORM_ADDR_W-1:0] worm_adr;
    logic [7:0]             worm_data;
    logic                   worm_wr;
    logic                   nvram_hps_rd;
    logic                   nvram_hps_wr;
    logic [DATA_W-1:0]      nvram_hps_din;
    nvram_core_t            nvram_core;
    logic                   backup_led;

    logic [31:0] lfsr_state;
    logic [7:0]  nv_table [0:(1 << WORM_ADDR_W)-1];
    sdram_req_t  rom_q [$];
    logic [20:0] worm_q [$];
    nvram_core_t restore_q [$];
    logic        rom_check;
    int          busy_left;
    int          refresh_seen;
    int          pass_seen;
    int          errors;

    tb_clock #(
        .PERIOD      (CLK_PERIOD),
        .RESET_CYCLES(RESET_CYCLES)
    ) u_tb_clock (
        .clk_sys     (clk_sys),
        .cditop_reset(cditop_reset)
    );

    cdi_host_glue #(
        .IGNORE_CYCLES(8)
    ) u_cdi_host_glue (
        .clk_sys              (clk_sys),
        .cditop_reset         (cditop_reset),
        .menu_reset           (menu_reset),
        .download             (download),
        .dl                   (dl),
        .core_req             (core_req),
        .sdram_busy           (sdram_busy),
        .sdram_dout           (sdram_dout),
        .sdram_burstdata_valid(sdram_burstdata_valid),
        .nvram_hps_ack        (nvram_hps_ack),
        .sd_buff_addr_lsb     (sd_buff_addr_lsb),
        .sd_buff_dout         (sd_buff_dout),
        .sd_buff_wr           (sd_buff_wr),
        .nvram_mount          (nvram_mount),
        .img_size_nonzero     (img_size_nonzero),
        .osd_status           (osd_status),
        .nvram_backup_data    (nvram_backup_data),
        .nvram_cpu_changed    (nvram_cpu_changed),
        .reset_on_mount       (reset_on_mount),
        .sdram_req            (sdram_req),
        .core_hold            (core_hold),
        .download_overflow    (download_overflow),
        .worm_adr             (worm_adr),
        .worm_data            (worm_data),
        .worm_wr              (worm_wr),
        .nvram_hps_rd         (nvram_hps_rd),
        .nvram_hps_wr         (nvram_hps_wr),
        .nvram_hps_din        (nvram_hps_din),
        .nvram_core           (nvram_core),
        .backup_led           (backup_led)
    );

    // Core NvRAM byte port answers from the table
    assign nvram_backup_data = nv_table[nvram_core.addr];

    // ============================================================
    // Random numbers and reference model
    // ============================================================

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit taken
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[62:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic sdram_req_t rom_expect(input logic [24:0] a, input logic [15:0] d);
        sdram_req_t r;
        r = '0;
        r.addr = {ROM_REGION_PREFIX, a[21:1], 1'b0};
        r.data = {d[7:0], d[15:8]};
        r.wr = 1'b1;
        r.word = 1'b1;
        return r;
    endfunction

    function automatic sdram_req_t refresh_expect();
        sdram_req_t r;
        r = '0;
        r.rd = 1'b1;
        r.refresh = 1'b1;
        r.word = 1'b1;
        return r;
    endfunction

    // Address and byte of one slave WORM write
    function automatic logic [20:0] worm_expect(input logic [24:0] a, input logic [15:0] d,
                                                input logic hi);
        return hi ? {a[12:1], 1'b1, d[15:8]} : {a[12:0], d[7:0]};
    endfunction

    function automatic nvram_core_t restore_expect(input int i, input logic [15:0] w,
                                                   input logic hi);
        return '{addr: 13'(2 * i + int'(hi)), restore_data: hi ? w[15:8] : w[7:0],
                 restore_write: 1'b1, allow_cpu_access: 1'b0};
    endfunction

    // High half from the odd byte
    function automatic logic [15:0] backup_expect(input int i);
        return {nv_table[2 * i + 1], nv_table[2 * i]};
    endfunction

    // ============================================================
    // Checks and failure handling
    // ============================================================

    task automatic stop_on_error();
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic abort_run(input string why);
        errors++;
        $display("%s at %0t ns", why, $time);
        stop_on_error();
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    function automatic logic watched(input string name);
        logic v;
        v = 1'bx;
        if (name == "nvram_hps_rd") v = nvram_hps_rd;
        else if (name == "nvram_hps_wr") v = nvram_hps_wr;
        else if (name == "backup_led") v = backup_led;
        else if (name == "allow_cpu_access") v = nvram_core.allow_cpu_access;
        else if (name == "core_hold") v = core_hold;
        else if (name == "rom_idle") v = (rom_q.size() == 0);
        return v;
    endfunction

    // Returns just after the edge where the level was seen
    task automatic wait_level(input string name, input logic level);
        int n;
        bit seen;
        n = 0;
        seen = 1'b0;
        while (!seen && n < WAIT_LIMIT) begin
            @(posedge clk_sys);
            seen = (watched(name) === level);
            n++;
        end
        if (!seen) abort_run({name, " did not reach the expected level"});
        else #1;
    endtask

    task automatic cycles(input int n);
        repeat (n) @(posedge clk_sys);
        #1;
    endtask

    task automatic send_beat(input logic worm, input int gap);
        logic [24:0] a;
        logic [15:0] d;
        a = 25'(rand_bits(25));
        d = 16'(rand_bits(16));
        if (worm) begin
            worm_q.push_back(worm_expect(a, d, 1'b0));
            worm_q.push_back(worm_expect(a, d, 1'b1));
        end else if (rom_check) begin
            rom_q.push_back(rom_expect(a, d));
        end
        dl = '{wr: 1'b1, addr: a, data: d, index6: worm};
        cycles(1);
        dl.wr = 1'b0;
        if (gap > 1) cycles(gap - 1);
    endtask

    // ============================================================
    // SDRAM busy model, monitor and watchdog
    // ============================================================

    always @(posedge clk_sys) begin
        if (sdram_busy) begin
            busy_left = busy_left - 1;
            if (busy_left == 0) #1 sdram_busy = 1'b0;
        end else if (sdram_req.rd === 1'b1 || sdram_req.wr === 1'b1) begin
            busy_left = BUSY_CYCLES;
            #1 sdram_busy = 1'b1;
        end
    end

    always @(posedge clk_sys) begin
        if (cditop_reset === 1'b0) begin
            if (core_hold === 1'b0) begin
                check("sdram_req", sdram_req, core_req);
                pass_seen++;
            end else if (sdram_busy === 1'b1) begin
                // Boot requests stay quiet during an access
                check("sdram_req.rd/wr", {sdram_req.rd, sdram_req.wr}, 2'b00);
            end else if (sdram_req.wr === 1'b1) begin
                if (rom_check && rom_q.size() == 0) begin
                    abort_run("SDRAM write issued with no ROM word sent");
                end else if (rom_check) begin
                    check("sdram_req", sdram_req, rom_q.pop_front());
                end
            end else if (sdram_req.rd === 1'b1) begin
                check("sdram_req", sdram_req, refresh_expect());
                refresh_seen++;
            end

            if (worm_wr === 1'b1) begin
                if (worm_q.size() == 0) abort_run("WORM write with no beat sent");
                else check("worm_adr/worm_data", {worm_adr, worm_data}, worm_q.pop_front());
            end

            if (nvram_core.restore_write === 1'b1) begin
                if (restore_q.size() == 0) abort_run("NvRAM restore write with no word sent");
                else check("nvram_core", nvram_core, restore_q.pop_front());
            end
        end
    end

    initial begin
        #(RUN_CYCLES * CLK_PERIOD);
        abort_run("watchdog expired before the tests finished");
    end

    // ============================================================
    // Stimulus
    // ============================================================

    initial begin
        logic [15:0] word;
        int          i;

        menu_reset = 1'b0;
        download = 1'b1;
        dl = '0;
        core_req = '0;
        sdram_busy = 1'b0;
        sdram_dout = '0;
        sdram_burstdata_valid = 1'b0;
        nvram_hps_ack = 1'b0;
        sd_buff_addr_lsb = 1'b0;
        sd_buff_dout = '0;
        sd_buff_wr = 1'b0;
        nvram_mount = 1'b0;
        img_size_nonzero = 1'b0;
        osd_status = 1'b0;
        nvram_cpu_changed = 1'b0;
        reset_on_mount = 1'b0;
        rom_check = 1'b1;
        busy_left = 0;
        refresh_seen = 0;
        pass_seen = 0;
        errors = 0;

        lfsr_state = 32'hf147;
        for (i = 0; i < (1 << WORM_ADDR_W); i++) begin
            nv_table[i] = 8'(rand_bits(8));
        end

        cycles(RESET_CYCLES + 1);

        // Boot ROM download with refresh in the gaps
        for (i = 0; i < ROM_BEATS; i++) begin
            send_beat(1'b0, ROM_GAP);
        end
        wait_level("rom_idle", 1'b1);
        check("download_overflow", download_overflow, 1'b0);
        check("refresh requests seen", refresh_seen != 0, 1'b1);

        for (i = 0; i < WORM_BEATS; i++) begin
            send_beat(1'b1, WORM_GAP);
        end

        // Second beat while the first is still pending
        cycles(10);
        rom_check = 1'b0;
        send_beat(1'b0, 1);
        send_beat(1'b0, 2);
        check("download_overflow", download_overflow, 1'b1);
        cycles(ROM_GAP);

        // Core owns SDRAM once download ends
        download = 1'b0;
        wait_level("core_hold", 1'b0);
        pass_seen = 0;
        for (i = 0; i < PASS_CYCLES; i++) begin
            core_req = REQ_W'(rand_bits(REQ_W));
            cycles(1);
        end
        core_req = '0;
        check("passthrough cycles", pass_seen >= PASS_CYCLES, 1'b1);

        // ============================================================
        // NvRAM restore from a freshly mounted image
        // ============================================================

        reset_on_mount = 1'b1;
        img_size_nonzero = 1'b1;
        nvram_mount = 1'b1;
        cycles(1);
        nvram_mount = 1'b0;
        @(posedge clk_sys);
        check("core_hold", core_hold, 1'b1);
        check("nvram_hps_rd", nvram_hps_rd, 1'b1);
        #1 nvram_hps_ack = 1'b1;
        wait_level("nvram_hps_rd", 1'b0);
        check("allow_cpu_access", nvram_core.allow_cpu_access, 1'b0);
        for (i = 0; i < NV_WORDS; i++) begin
            word = 16'(rand_bits(16));
            restore_q.push_back(restore_expect(i, word, 1'b0));
            restore_q.push_back(restore_expect(i, word, 1'b1));
            sd_buff_dout = word;
            sd_buff_wr = 1'b1;
            cycles(1);
            sd_buff_wr = 1'b0;
            cycles(RESTORE_GAP - 1);
        end
        nvram_hps_ack = 1'b0;
        wait_level("allow_cpu_access", 1'b1);
        check("restore writes left", restore_q.size(), 0);

        // ============================================================
        // NvRAM backup after a CPU change
        // ============================================================

        nvram_cpu_changed = 1'b1;
        cycles(1);
        nvram_cpu_changed = 1'b0;
        wait_level("backup_led", 1'b1);
        osd_status = 1'b1;
        wait_level("nvram_hps_wr", 1'b1);
        check("backup_led", backup_led, 1'b0);
        nvram_hps_ack = 1'b1;
        wait_level("nvram_hps_wr", 1'b0);
        for (i = 0; i < NV_WORDS; i++) begin
            repeat (BACKUP_GAP) @(posedge clk_sys);
            check("nvram_hps_din", nvram_hps_din, backup_expect(i));
            #1 sd_buff_addr_lsb = ~sd_buff_addr_lsb;
        end
        nvram_hps_ack = 1'b0;
        osd_status = 1'b0;
        wait_level("allow_cpu_access", 1'b1);

        check("ROM writes left", rom_q.size(), 0);
        check("WORM writes left", worm_q.size(), 0);

        if (errors == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            abort_run("errors were counted during the run");
        end
    end

endmodule

// ==== sources.f ====
source/cdi_glue_pkg.sv
source/rom_loader.sv
source/worm_loader.sv
source/sdram_arbiter.sv
source/nvram_sync.sv
source/cdi_host_glue.sv
tests/tb_clock.sv
tests/tb_cdi_host_glue.sv

// ==== Bender.yml ====
package:
  name: cdi_host_glue

sources:
  - files:
      - source/cdi_glue_pkg.sv
      - source/rom_loader.sv
      - source/worm_loader.sv
      - source/sdram_arbiter.sv
      - source/nvram_sync.sv
      - source/cdi_host_glue.sv
  - target: simulation
    files:
      - tests/tb_clock.sv
      - tests/tb_cdi_host_glue.sv
